// ==== alu_cfg.svh ====
// ALU datapath configuration
// Data, opcode and condition-code widths shared by packages and RTL

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand and result width
`define ALU_WIDTH 16

// Opcode enum width, room for 32 encodings
`define ALU_OP_BITS 5

// Condition-code enum width
`define COND_BITS 3

`endif

// ==== aluPkg.sv ====
// ALU types
// Control word, opcode set and flag bundle of the flag-driven ALU

`default_nettype none
`include "alu_cfg.svh"

package aluPkg;

    // Six control bits, ex is the MSB
    typedef struct packed {
        logic ex;
        logic nx;
        logic ey;
        logic ny;
        logic f;
        logic no;
    } aluCtrl_t;

    typedef enum logic [`ALU_OP_BITS-1:0] {
        opZero,
        opOne,
        opMinusOne,
        opX,
        opY,
        opNotX,
        opNotY,
        opNegX,
        opNegY,
        opIncX,
        opIncY,
        opDecX,
        opDecY,
        opAdd,
        opSubXY,
        opSubYX,
        opAnd,
        opOr
    } aluOp_e;

    // Carry is only meaningful for adder ops
    typedef struct packed {
        logic zero;
        logic lt;
        logic carry;
    } aluFlags_t;

endpackage

`default_nettype wire

// ==== datapathPkg.sv ====
// Datapath types
// Condition codes tested against stored flags and the per-exec request

`default_nettype none
`include "alu_cfg.svh"

package datapathPkg;

    typedef enum logic [`COND_BITS-1:0] {
        condNever,
        condGt,
        condEq,
        condGe,
        condLt,
        condNe,
        condLe,
        condAlways
    } cond_e;

    // Operation issued with exec
    typedef struct packed {
        aluPkg::aluOp_e op;
        logic           useCarry;
    } opReq_t;

endpackage

`default_nettype wire

// ==== operandRegs.sv ====
// Operand registers
// X and Y each load dataIn on their own strobe and hold otherwise

`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module operandRegs (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`ALU_WIDTH-1:0] dataIn,
    input  logic                  loadX,
    input  logic                  loadY,
    output logic [`ALU_WIDTH-1:0] x,
    output logic [`ALU_WIDTH-1:0] y
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            x <= '0;
        end else if (loadX) begin
            x <= dataIn;
        end
    end

    // Loads independently, both may fire together
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            y <= '0;
        end else if (loadY) begin
            y <= dataIn;
        end
    end

    // X must hold across any edge without loadX
    assert property (@(posedge clk) disable iff (!rstN)
        !loadX |=> $stable(x));

endmodule

`default_nettype wire

// ==== alu.sv ====
// Flag-driven ALU
// Decodes an opcode into ex/nx/ey/ny/f/no, computes on x and y, registers result and flags

`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module alu (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  exec,
    input  aluPkg::aluOp_e        op,
    input  logic                  carryIn,
    input  logic [`ALU_WIDTH-1:0] x,
    input  logic [`ALU_WIDTH-1:0] y,
    output logic [`ALU_WIDTH-1:0] result,
    output aluPkg::aluFlags_t     newFlags,
    output logic                  flagsValid
);

    aluPkg::aluCtrl_t      ctrl;
    logic [`ALU_WIDTH-1:0] xg;
    logic [`ALU_WIDTH-1:0] yg;
    logic [`ALU_WIDTH:0]   sum;
    logic                  addCin;
    logic [`ALU_WIDTH-1:0] fOut;
    logic [`ALU_WIDTH-1:0] outVal;
    aluPkg::aluFlags_t     flagsNext;

    // Bit order ex_nx_ey_ny_f_no
    always_comb begin
        case (op)
            aluPkg::opZero:     ctrl = 6'b0_0_0_0_1_0;
            aluPkg::opOne:      ctrl = 6'b0_1_0_1_1_1;
            aluPkg::opMinusOne: ctrl = 6'b0_1_0_1_0_0;
            aluPkg::opX:        ctrl = 6'b1_0_0_0_1_0;
            aluPkg::opY:        ctrl = 6'b0_0_1_0_1_0;
            aluPkg::opNotX:     ctrl = 6'b1_1_0_0_1_0;
            aluPkg::opNotY:     ctrl = 6'b0_0_1_1_1_0;
            aluPkg::opNegX:     ctrl = 6'b1_0_0_1_1_1;
            aluPkg::opNegY:     ctrl = 6'b0_1_1_0_1_1;
            aluPkg::opIncX:     ctrl = 6'b1_1_0_1_1_1;
            aluPkg::opIncY:     ctrl = 6'b0_1_1_1_1_1;
            aluPkg::opDecX:     ctrl = 6'b1_0_0_1_1_0;
            aluPkg::opDecY:     ctrl = 6'b0_1_1_0_1_0;
            aluPkg::opAdd:      ctrl = 6'b1_0_1_0_1_0;
            aluPkg::opSubXY:    ctrl = 6'b1_1_1_0_1_1;
            aluPkg::opSubYX:    ctrl = 6'b1_0_1_1_1_1;
            aluPkg::opAnd:      ctrl = 6'b1_0_1_0_0_0;
            aluPkg::opOr:       ctrl = 6'b1_1_1_1_0_1;
            default:            ctrl = '0;
        endcase
    end

    // Gate then optionally invert each operand
    always_comb begin
        xg = ctrl.ex ? x : '0;
        if (ctrl.nx) begin
            xg = ~xg;
        end
        yg = ctrl.ey ? y : '0;
        if (ctrl.ny) begin
            yg = ~yg;
        end
    end

    assign addCin = ctrl.f & carryIn;
    assign sum    = {1'b0, xg} + {1'b0, yg} + {{`ALU_WIDTH{1'b0}}, addCin};
    assign fOut   = ctrl.f ? sum[`ALU_WIDTH-1:0] : (xg & yg);
    assign outVal = ctrl.no ? ~fOut : fOut;

    always_comb begin
        flagsNext.zero  = (outVal == '0);
        flagsNext.lt    = outVal[`ALU_WIDTH-1];
        flagsNext.carry = ctrl.f & sum[`ALU_WIDTH];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result     <= '0;
            newFlags   <= '0;
            flagsValid <= 1'b0;
        end else begin
            flagsValid <= exec;
            if (exec) begin
                result   <= outVal;
                newFlags <= flagsNext;
            end
        end
    end

    // flagsValid is exactly the delayed exec strobe
    assert property (@(posedge clk) disable iff (!rstN)
        flagsValid |-> $past(exec));

    // Zero flag travels with its result
    assert property (@(posedge clk) disable iff (!rstN)
        flagsValid |-> (newFlags.zero == (result == '0)));

endmodule

`default_nettype wire

// ==== statusReg.sv ====
// Status register
// Stores ALU flags, feeds carry for chained adds, evaluates condition codes

`timescale 1ns/100ps
`default_nettype none

module statusReg (
    input  logic                clk,
    input  logic                rstN,
    input  logic                flagsValid,
    input  aluPkg::aluFlags_t   newFlags,
    input  logic                useCarry,
    input  datapathPkg::cond_e  cond,
    output logic                carryIn,
    output aluPkg::aluFlags_t   flags,
    output logic                condTrue
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagsValid) begin
            flags <= newFlags;
        end
    end

    assign carryIn = useCarry & flags.carry;

    always_comb begin
        condTrue = 1'b0;
        case (cond)
            datapathPkg::condNever:  condTrue = 1'b0;
            datapathPkg::condGt:     condTrue = !flags.lt && !flags.zero;
            datapathPkg::condEq:     condTrue = flags.zero;
            datapathPkg::condGe:     condTrue = !flags.lt;
            datapathPkg::condLt:     condTrue = flags.lt;
            datapathPkg::condNe:     condTrue = !flags.zero;
            datapathPkg::condLe:     condTrue = flags.lt || flags.zero;
            datapathPkg::condAlways: condTrue = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== aluDatapath.sv ====
// ALU datapath top
// Operand registers, ALU and status register with a bus-style result output

`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module aluDatapath (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`ALU_WIDTH-1:0] dataIn,
    input  logic                  loadX,
    input  logic                  loadY,
    input  logic                  exec,
    input  datapathPkg::opReq_t   req,
    input  datapathPkg::cond_e    cond,
    input  logic                  busEnable,
    output logic [`ALU_WIDTH-1:0] busData,
    output logic                  busDrive,
    output aluPkg::aluFlags_t     flags,
    output logic                  condTrue
);

    logic [`ALU_WIDTH-1:0] opX;
    logic [`ALU_WIDTH-1:0] opY;
    logic                  carryIn;
    aluPkg::aluFlags_t     newFlags;
    logic                  flagsValid;

    operandRegs uOperandRegs (
        .clk    (clk),
        .rstN   (rstN),
        .dataIn (dataIn),
        .loadX  (loadX),
        .loadY  (loadY),
        .x      (opX),
        .y      (opY)
    );

    // Registered result doubles as the bus value
    alu uAlu (
        .clk        (clk),
        .rstN       (rstN),
        .exec       (exec),
        .op         (req.op),
        .carryIn    (carryIn),
        .x          (opX),
        .y          (opY),
        .result     (busData),
        .newFlags   (newFlags),
        .flagsValid (flagsValid)
    );

    statusReg uStatusReg (
        .clk        (clk),
        .rstN       (rstN),
        .flagsValid (flagsValid),
        .newFlags   (newFlags),
        .useCarry   (req.useCarry),
        .cond       (cond),
        .carryIn    (carryIn),
        .flags      (flags),
        .condTrue   (condTrue)
    );

    // No tristate, drive level marks busData valid
    assign busDrive = busEnable;

endmodule

`default_nettype wire

// ==== aluChecker.sv ====
// ALU datapath checker
// Mirrors the operand, result and flag registers from opcode arithmetic and compares outputs

`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module aluChecker (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`ALU_WIDTH-1:0] dataIn,
    input  logic                  loadX,
    input  logic                  loadY,
    input  logic                  exec,
    input  datapathPkg::opReq_t   req,
    input  datapathPkg::cond_e    cond,
    input  logic                  busEnable,
    input  logic [`ALU_WIDTH-1:0] busData,
    input  logic                  busDrive,
    input  aluPkg::aluFlags_t     flags,
    input  logic                  condTrue,
    output int                    errorCount,
    output int                    checkCount
);

    localparam int W = `ALU_WIDTH;

    int errors = 0;
    int checks = 0;

    logic [W-1:0]      mX;
    logic [W-1:0]      mY;
    logic [W-1:0]      mResult;
    aluPkg::aluFlags_t mFlags;
    logic              mCarryKnown;
    // Flags of the exec one edge back, stored at the next edge
    aluPkg::aluFlags_t pendFlags;
    logic              pendCarryKnown;
    logic              pendValid;

    assign errorCount = errors;
    assign checkCount = checks;

    function automatic logic [W-1:0] expectResult(input aluPkg::aluOp_e op,
            input logic [W-1:0] a, input logic [W-1:0] b, input logic cin);
        logic [W-1:0] res;
        case (op)
            aluPkg::opZero:     res = '0;
            aluPkg::opOne:      res = W'(1);
            aluPkg::opMinusOne: res = '1;
            aluPkg::opX:        res = a;
            aluPkg::opY:        res = b;
            aluPkg::opNotX:     res = ~a;
            aluPkg::opNotY:     res = ~b;
            aluPkg::opNegX:     res = -a;
            aluPkg::opNegY:     res = -b;
            aluPkg::opIncX:     res = a + W'(1);
            aluPkg::opIncY:     res = b + W'(1);
            aluPkg::opDecX:     res = a - W'(1);
            aluPkg::opDecY:     res = b - W'(1);
            aluPkg::opAdd:      res = a + b + W'(cin);
            aluPkg::opSubXY:    res = a - b;
            aluPkg::opSubYX:    res = b - a;
            aluPkg::opAnd:      res = a & b;
            aluPkg::opOr:       res = a | b;
            default:            res = '0;
        endcase
        return res;
    endfunction

    function automatic logic expectCond(input datapathPkg::cond_e c,
            input aluPkg::aluFlags_t f);
        case (c)
            datapathPkg::condNever:  return 1'b0;
            datapathPkg::condGt:     return !f.lt && !f.zero;
            datapathPkg::condEq:     return f.zero;
            datapathPkg::condGe:     return !f.lt;
            datapathPkg::condLt:     return f.lt;
            datapathPkg::condNe:     return !f.zero;
            datapathPkg::condLe:     return f.lt || f.zero;
            default:                 return 1'b1;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [W-1:0] actual,
            input logic [W-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected 0x%h, actual 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic compareOutputs();
        checkValue("busData", busData, mResult);
        checkValue("busDrive", W'(busDrive), W'(busEnable));
        checkValue("flags.zero", W'(flags.zero), W'(mFlags.zero));
        checkValue("flags.lt", W'(flags.lt), W'(mFlags.lt));
        if (mCarryKnown) begin
            checkValue("flags.carry", W'(flags.carry), W'(mFlags.carry));
        end
        checkValue("condTrue", W'(condTrue), W'(expectCond(cond, mFlags)));
    endtask

    // Advance the mirrored registers by one clock edge
    task automatic stepModel();
        aluPkg::aluFlags_t nextStored;
        logic              nextKnown;
        logic              cin;
        logic [W:0]        wide;
        nextStored = mFlags;
        nextKnown  = mCarryKnown;
        if (pendValid) begin
            nextStored = pendFlags;
            nextKnown  = pendCarryKnown;
        end
        pendValid = exec;
        if (exec) begin
            if (req.useCarry && !mCarryKnown) begin
                errors++;
                $display("Chained add issued while the stored carry is undefined at %0t", $time);
            end
            cin            = req.useCarry & mFlags.carry;
            mResult        = expectResult(req.op, mX, mY, cin);
            pendFlags.zero = (mResult == '0);
            pendFlags.lt   = mResult[W-1];
            // Carry only defined by the zero, add, AND and OR meanings
            wide           = {1'b0, mX} + {1'b0, mY} + (W+1)'(cin);
            pendFlags.carry = (req.op == aluPkg::opAdd) ? wide[W] : 1'b0;
            pendCarryKnown  = (req.op == aluPkg::opAdd) || (req.op == aluPkg::opAnd) ||
                              (req.op == aluPkg::opOr) || (req.op == aluPkg::opZero);
        end
        mFlags      = nextStored;
        mCarryKnown = nextKnown;
        if (loadX) begin
            mX = dataIn;
        end
        if (loadY) begin
            mY = dataIn;
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            mX             = '0;
            mY             = '0;
            mResult        = '0;
            mFlags         = '0;
            mCarryKnown    = 1'b1;
            pendFlags      = '0;
            pendCarryKnown = 1'b1;
            pendValid      = 1'b0;
        end else begin
            compareOutputs();
            stepModel();
        end
    end

endmodule

`default_nettype wire

// ==== tbAluDatapath.sv ====
// ALU datapath testbench
// Loads operand pairs and runs a table of ops and condition codes through the DUT

`timescale 1ns/100ps
`default_nettype none
`include "alu_cfg.svh"

module tbAluDatapath;

    localparam int W         = `ALU_WIDTH;
    localparam int numRows   = 22;
    localparam int numPairs  = 33;
    // Per-pair overhead of load and idle cycles
    localparam int timeoutNs = (numPairs * (numRows + 4) + 50) * 10;

    localparam logic [W-1:0] corners [5] = '{16'h0000, 16'h0001, 16'h7FFF, 16'h8000, 16'hFFFF};

    typedef struct packed {
        aluPkg::aluOp_e     op;
        logic               useCarry;
        datapathPkg::cond_e cond;
    } stimRow_t;

    logic                clk;
    logic                rstN;
    logic [W-1:0]        dataIn;
    logic                loadX;
    logic                loadY;
    logic                exec;
    datapathPkg::opReq_t req;
    datapathPkg::cond_e  cond;
    logic                busEnable;
    logic [W-1:0]        busData;
    logic                busDrive;
    aluPkg::aluFlags_t   flags;
    logic                condTrue;
    int                  errorCount;
    int                  checkCount;

    stimRow_t     stimTable [numRows];
    logic [W-1:0] xs [numPairs];
    logic [W-1:0] ys [numPairs];

    aluDatapath uut (
        .clk       (clk),
        .rstN      (rstN),
        .dataIn    (dataIn),
        .loadX     (loadX),
        .loadY     (loadY),
        .exec      (exec),
        .req       (req),
        .cond      (cond),
        .busEnable (busEnable),
        .busData   (busData),
        .busDrive  (busDrive),
        .flags     (flags),
        .condTrue  (condTrue)
    );

    aluChecker uChecker (
        .clk        (clk),
        .rstN       (rstN),
        .dataIn     (dataIn),
        .loadX      (loadX),
        .loadY      (loadY),
        .exec       (exec),
        .req        (req),
        .cond       (cond),
        .busEnable  (busEnable),
        .busData    (busData),
        .busDrive   (busDrive),
        .flags      (flags),
        .condTrue   (condTrue),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    always #5 clk = ~clk;

    // Carry chains reach two rows back, so useCarry rows sit two after an opAdd
    initial begin
        stimTable[0]  = '{aluPkg::opZero,     1'b0, datapathPkg::condNever};
        stimTable[1]  = '{aluPkg::opOne,      1'b0, datapathPkg::condGt};
        stimTable[2]  = '{aluPkg::opMinusOne, 1'b0, datapathPkg::condEq};
        stimTable[3]  = '{aluPkg::opX,        1'b0, datapathPkg::condGe};
        stimTable[4]  = '{aluPkg::opY,        1'b0, datapathPkg::condLt};
        stimTable[5]  = '{aluPkg::opNotX,     1'b0, datapathPkg::condNe};
        stimTable[6]  = '{aluPkg::opNotY,     1'b0, datapathPkg::condLe};
        stimTable[7]  = '{aluPkg::opNegX,     1'b0, datapathPkg::condAlways};
        stimTable[8]  = '{aluPkg::opNegY,     1'b0, datapathPkg::condGt};
        stimTable[9]  = '{aluPkg::opIncX,     1'b0, datapathPkg::condEq};
        stimTable[10] = '{aluPkg::opIncY,     1'b0, datapathPkg::condGe};
        stimTable[11] = '{aluPkg::opDecX,     1'b0, datapathPkg::condLt};
        stimTable[12] = '{aluPkg::opDecY,     1'b0, datapathPkg::condNe};
        stimTable[13] = '{aluPkg::opAdd,      1'b0, datapathPkg::condLe};
        stimTable[14] = '{aluPkg::opAnd,      1'b0, datapathPkg::condAlways};
        stimTable[15] = '{aluPkg::opAdd,      1'b1, datapathPkg::condGt};
        stimTable[16] = '{aluPkg::opOr,       1'b0, datapathPkg::condEq};
        stimTable[17] = '{aluPkg::opSubXY,    1'b0, datapathPkg::condGe};
        stimTable[18] = '{aluPkg::opSubYX,    1'b0, datapathPkg::condLt};
        stimTable[19] = '{aluPkg::opAdd,      1'b0, datapathPkg::condNever};
        stimTable[20] = '{aluPkg::opAnd,      1'b0, datapathPkg::condNe};
        stimTable[21] = '{aluPkg::opAdd,      1'b1, datapathPkg::condEq};
    end

    // Load X then Y, one idle cycle, then one exec per table row
    task automatic runPair(input logic [W-1:0] xVal, input logic [W-1:0] yVal);
        @(posedge clk);
        dataIn <= xVal;
        loadX  <= 1'b1;
        exec   <= 1'b0;
        @(posedge clk);
        dataIn <= yVal;
        loadX  <= 1'b0;
        loadY  <= 1'b1;
        @(posedge clk);
        loadY     <= 1'b0;
        busEnable <= ~busEnable;
        for (int r = 0; r < numRows; r++) begin
            @(posedge clk);
            exec         <= 1'b1;
            req.op       <= stimTable[r].op;
            req.useCarry <= stimTable[r].useCarry;
            cond         <= stimTable[r].cond;
            busEnable    <= ~busEnable;
        end
    endtask

    initial begin
        void'($urandom(48793));
        clk       = 1'b0;
        rstN      = 1'b0;
        dataIn    = '0;
        loadX     = 1'b0;
        loadY     = 1'b0;
        exec      = 1'b0;
        req       = '0;
        cond      = datapathPkg::condEq;
        busEnable = 1'b0;
        for (int i = 0; i < 25; i++) begin
            xs[i] = corners[i / 5];
            ys[i] = corners[i % 5];
        end
        for (int k = 25; k < numPairs; k++) begin
            xs[k] = W'($urandom());
            ys[k] = W'($urandom());
        end
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        for (int p = 0; p < numPairs; p++) begin
            runPair(xs[p], ys[p]);
        end
        @(posedge clk);
        exec <= 1'b0;
        // Let the last flags settle and hold the result a few cycles
        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
aluPkg.sv
datapathPkg.sv
operandRegs.sv
alu.sv
statusReg.sv
aluDatapath.sv
aluChecker.sv
tbAluDatapath.sv

// ==== run.sh ====
#!/bin/sh
# Build the ALU datapath testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tbAluDatapath -f project.f -o simAluDatapath \
    && ./obj_dir/simAluDatapath | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation result: PASS" && exit 0 \
    || { echo "Simulation result: FAIL"; exit 1; }
